// ==== addSubUnit.sv ====
// ripple-carry adder/subtractor built from 4-bit carry groups with signed overflow
`timescale 1ns/1ps

module addSubUnit
(
    input  logic [aluOpPkg::dataWidth-1:0] a,
    input  logic [aluOpPkg::dataWidth-1:0] b,
    input  aluOpPkg::aluOpT                op,
    output aluResPkg::addOutT              addOut
);
    import aluOpPkg::*;

    logic                 subtract;    // sub and slt both compute a - b
    logic [dataWidth-1:0] bEff;        // b or its inverse
    logic [dataWidth-1:0] sum;
    logic [numGroups:0]   groupCarry;  // carry between groups with [0] as the carry-in
    logic                 msbCarryIn;  // carry into bit 31

    // one bit of the ripple returning {carry, sum}
    function automatic logic [1:0] fullAdd
    (
        input logic x,
        input logic y,
        input logic cin
    );
        logic s;
        logic cout;

        s    = x ^ y ^ cin;
        cout = (x & y) | (x & cin) | (y & cin);
        return {cout, s};
    endfunction

    always_comb
    begin
        case (op)
            opSub,
            opSlt:   subtract = 1'b1;
            default: subtract = 1'b0;
        endcase
    end

    // two's complement subtract as a + ~b + 1
    assign bEff          = subtract ? ~b : b;
    assign groupCarry[0] = subtract;

    for (genvar g = 0; g < numGroups; g++)
    begin : gGroup
        logic [groupWidth:0] bitCarry;

        assign bitCarry[0] = groupCarry[g];

        for (genvar i = 0; i < groupWidth; i++)
        begin : gBit
            assign {bitCarry[i+1], sum[g*groupWidth+i]} =
                fullAdd(a[g*groupWidth+i], bEff[g*groupWidth+i], bitCarry[i]);
        end

        assign groupCarry[g+1] = bitCarry[groupWidth];

        // the top group also exposes the carry into its last bit
        if (g == numGroups - 1)
        begin : gTop
            assign msbCarryIn = bitCarry[groupWidth-1];
        end
    end

    assign addOut.sum      = sum;
    assign addOut.carry    = groupCarry[numGroups];
    assign addOut.overflow = groupCarry[numGroups] ^ msbCarryIn;  // sign carry mismatch

endmodule

// ==== alu32.sv ====
// 32-bit ALU top with add/sub and logic units feeding a registered result stage
`timescale 1ns/1ps

module alu32
(
    input  logic                clk,
    input  logic                rstN,
    input  logic                reqValid,
    input  aluOpPkg::aluReqT    req,
    output logic                respValid,
    output aluResPkg::aluRespT  resp
);
    import aluOpPkg::*;
    import aluResPkg::*;

    addOutT               addOut;
    logic [dataWidth-1:0] logicResult;

    // both units see the raw request every cycle
    addSubUnit i_addSubUnit
    (
        .a      (req.a),
        .b      (req.b),
        .op     (req.op),
        .addOut (addOut)
    );

    logicUnit i_logicUnit
    (
        .a           (req.a),
        .b           (req.b),
        .op          (req.op),
        .logicResult (logicResult)
    );

    resultSelect i_resultSelect
    (
        .clk         (clk),
        .rstN        (rstN),
        .reqValid    (reqValid),
        .op          (req.op),
        .addOut      (addOut),
        .logicResult (logicResult),
        .respValid   (respValid),
        .resp        (resp)
    );

endmodule

// ==== aluOpPkg.sv ====
// ALU request package with opcode encoding, datapath widths and the request struct
package aluOpPkg;

    // datapath sizing
    localparam int dataWidth  = 32;
    localparam int groupWidth = 4;                      // bits per ripple carry group
    localparam int numGroups  = dataWidth / groupWidth;

    // codes 8 to 15 are illegal and give a zero result
    typedef enum logic [3:0]
    {
        opAdd  = 4'h0,
        opSub  = 4'h1,
        opSlt  = 4'h2,  // signed set-less-than
        opAnd  = 4'h3,
        opOr   = 4'h4,
        opXor  = 4'h5,
        opNor  = 4'h6,
        opNand = 4'h7
    } aluOpT;

    // one operation as it enters the ALU
    typedef struct packed
    {
        aluOpT                op;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
    } aluReqT;

endpackage

// ==== aluResPkg.sv ====
// ALU response package with the flag, adder output and response structs
package aluResPkg;

    typedef struct packed
    {
        logic zero;
        logic negative;
        logic carry;     // add and sub only
        logic overflow;  // add and sub only
    } aluFlagsT;

    // what the add/sub unit hands to the result stage
    typedef struct packed
    {
        logic [aluOpPkg::dataWidth-1:0] sum;
        logic                           carry;
        logic                           overflow;
    } addOutT;

    // registered result with its flags
    typedef struct packed
    {
        logic [aluOpPkg::dataWidth-1:0] result;
        aluFlagsT                       flags;
    } aluRespT;

endpackage

// ==== aluTb.sv ====
// testbench for the 32-bit ALU, table driven with directed and LFSR operands
`timescale 1ns/1ps

module aluTb;
    import aluOpPkg::*;
    import aluResPkg::*;

    localparam int numTests     = 64;
    localparam int numDirected  = 18;
    localparam int resetCycles  = 10;
    localparam int drainCycles  = 20;
    localparam int timeoutLimit = numTests * 4 + resetCycles + drainCycles;

    // one request waiting for its response
    typedef struct packed
    {
        int      testId;
        int      due;     // cycle on which respValid must be seen
        aluReqT  req;
        aluRespT exp;
    } pendingT;

    logic    clk = 1'b0;
    logic    rstN;
    logic    reqValid;
    aluReqT  req;
    logic    respValid;
    aluRespT resp;

    aluReqT  reqTab [numTests];
    aluRespT expTab [numTests];
    int      gapTab [numTests];  // idle cycles after the row

    pendingT     pending[$];
    pendingT     seen;
    aluRespT     lastResp   = '0;
    logic [31:0] lfsrState  = 32'heda8;
    int          cycleCount = 0;
    int          errorCount = 0;
    int          testsDone  = 0;
    int          testsFailed = 0;

    alu32 i_alu32
    (
        .clk       (clk),
        .rstN      (rstN),
        .reqValid  (reqValid),
        .req       (req),
        .respValid (respValid),
        .resp      (resp)
    );

    always #5 clk = ~clk;

    // fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic fb;

        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic takeBits(input int n, output logic [31:0] val);
        val = '0;
        for (int k = 0; k < n; k++)
        begin
            lfsrState = lfsrNext(lfsrState);
            val       = {val[30:0], lfsrState[0]};
        end
    endtask

    // reference model of the ALU result rules
    function automatic aluRespT predictResp(input aluReqT r);
        aluRespT     p;
        logic [31:0] bIn;
        logic        cin;
        logic [32:0] full;
        logic [31:0] low31;

        p = '0;
        case (r.op)
            opAdd,
            opSub:
            begin
                cin   = (r.op == opSub);
                bIn   = cin ? ~r.b : r.b;
                full  = {1'b0, r.a} + {1'b0, bIn} + 33'(cin);
                low31 = {1'b0, r.a[30:0]} + {1'b0, bIn[30:0]} + 32'(cin);  // [31] is carry into msb
                p.result         = full[31:0];
                p.flags.carry    = full[32];
                p.flags.overflow = full[32] ^ low31[31];
            end
            opSlt:   p.result = ($signed(r.a) < $signed(r.b)) ? 32'd1 : 32'd0;
            opAnd:   p.result = r.a & r.b;
            opOr:    p.result = r.a | r.b;
            opXor:   p.result = r.a ^ r.b;
            opNor:   p.result = ~(r.a | r.b);
            opNand:  p.result = ~(r.a & r.b);
            default: p.result = '0;
        endcase
        p.flags.zero     = (p.result == '0);
        p.flags.negative = p.result[31];
        return p;
    endfunction

    function automatic string opLabel(input aluOpT op);
        case (op)
            opAdd:   return "add";
            opSub:   return "sub";
            opSlt:   return "slt";
            opAnd:   return "and";
            opOr:    return "or";
            opXor:   return "xor";
            opNor:   return "nor";
            opNand:  return "nand";
            default: return "illegal";
        endcase
    endfunction

    task automatic setRow
    (
        input int          idx,
        input aluOpT       opCode,
        input logic [31:0] a,
        input logic [31:0] b,
        input int          gap
    );
        reqTab[idx].op = opCode;
        reqTab[idx].a  = a;
        reqTab[idx].b  = b;
        expTab[idx]    = predictResp(reqTab[idx]);
        gapTab[idx]    = gap;
    endtask

    task automatic buildTable();
        logic [31:0] opBits;
        logic [31:0] aRand;
        logic [31:0] bRand;
        logic [31:0] gapBits;

        setRow(0,  opAdd,  32'hffffffff, 32'h00000001, 0);  // wraps to zero with carry
        setRow(1,  opAdd,  32'h7fffffff, 32'h00000001, 0);  // signed overflow
        setRow(2,  opAdd,  32'h12345678, 32'h87654321, 1);
        setRow(3,  opSub,  32'h80000000, 32'h00000001, 0);  // most negative minus one
        setRow(4,  opSub,  32'h00000005, 32'h00000005, 0);
        setRow(5,  opSub,  32'h00000000, 32'h00000001, 2);
        setRow(6,  opSlt,  32'h00000005, 32'h00000005, 0);
        setRow(7,  opSlt,  32'hffffffff, 32'h00000001, 0);
        setRow(8,  opSlt,  32'h00000001, 32'hffffffff, 0);
        setRow(9,  opSlt,  32'h80000000, 32'h00000001, 1);  // difference overflows
        setRow(10, opSlt,  32'h7fffffff, 32'h80000000, 0);
        setRow(11, opAnd,  32'hf0f0f0f0, 32'h0f0f0f0f, 0);
        setRow(12, opOr,   32'hf0f0f0f0, 32'h0f0f0f0f, 0);
        setRow(13, opXor,  32'ha5a5a5a5, 32'hffffffff, 1);
        setRow(14, opNor,  32'h00000000, 32'h00000000, 0);
        setRow(15, opNand, 32'hffffffff, 32'hffffffff, 0);
        setRow(16, aluOpT'(4'h8), 32'h12345678, 32'h9abcdef0, 1);
        setRow(17, aluOpT'(4'hf), 32'hffffffff, 32'hffffffff, 0);

        // random rows where a gap of 3 folds to 0 so back-to-back is common
        for (int i = numDirected; i < numTests; i++)
        begin
            takeBits(3, opBits);
            takeBits(32, aRand);
            takeBits(32, bRand);
            takeBits(2, gapBits);
            setRow(i, aluOpT'({1'b0, opBits[2:0]}), aRand, bRand,
                   (gapBits[1:0] == 2'd3) ? 0 : int'(gapBits[1:0]));
        end
    endtask

    task automatic checkResponse(input pendingT e);
        int bad;

        bad = 0;
        if (e.due != cycleCount)
        begin
            $display("test %0d: response came on cycle %0d instead of cycle %0d",
                     e.testId, cycleCount, e.due);
            bad++;
        end
        if (resp.result !== e.exp.result)
        begin
            $display("ERROR test %0d resp.result exp 0x%h got 0x%h",
                     e.testId, e.exp.result, resp.result);
            bad++;
        end
        if (resp.flags !== e.exp.flags)
        begin
            $display("ERROR test %0d resp.flags exp 0x%h got 0x%h",
                     e.testId, e.exp.flags, resp.flags);
            bad++;
        end
        testsDone++;
        errorCount += bad;
        if (bad == 0)
            $display("test %0d %s a=%h b=%h ok", e.testId, opLabel(e.req.op), e.req.a, e.req.b);
        else
        begin
            testsFailed++;
            $display("test %0d %s a=%h b=%h failed", e.testId, opLabel(e.req.op),
                     e.req.a, e.req.b);
        end
    endtask

    // cycle counter and run limit
    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutLimit)
        begin
            $display("run stopped: no finish after %0d cycles", cycleCount);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // outputs are sampled mid cycle where they are stable
    always @(negedge clk)
    begin
        if (cycleCount > 0)  // nothing is defined before the first edge
        begin
            if (respValid !== 1'b0 && respValid !== 1'b1)
            begin
                $display("respValid is unknown on cycle %0d", cycleCount);
                errorCount++;
            end
            else if (!rstN)
            begin
                if (respValid || resp !== '0)
                begin
                    $display("respValid or resp not cleared during reset on cycle %0d",
                             cycleCount);
                    errorCount++;
                end
            end
            else if (respValid)
            begin
                if (pending.size() == 0)
                begin
                    $display("response on cycle %0d with no request outstanding", cycleCount);
                    errorCount++;
                end
                else
                begin
                    seen = pending.pop_front();
                    checkResponse(seen);
                end
                lastResp = resp;
            end
            else
            begin
                if (resp !== lastResp)
                begin
                    $display("resp changed without a strobe on cycle %0d", cycleCount);
                    errorCount++;
                end
                if (pending.size() != 0 && pending[0].due <= cycleCount)
                begin
                    seen = pending.pop_front();
                    $display("test %0d %s got no response on cycle %0d", seen.testId,
                             opLabel(seen.req.op), seen.due);
                    testsDone++;
                    testsFailed++;
                    errorCount++;
                end
            end
        end
    end

    initial
    begin
        pendingT entry;

        rstN     = 1'b0;
        reqValid = 1'b1;  // strobe held during reset must not reach the outputs
        req      = '1;
        buildTable();

        repeat (resetCycles) @(posedge clk);
        #1;
        rstN     = 1'b1;
        reqValid = 1'b0;
        req      = '0;
        repeat (3) @(posedge clk);  // resp must stay zero while idle after reset
        $display("reset check done");

        for (int i = 0; i < numTests; i++)
        begin
            @(posedge clk);
            #1;
            reqValid     = 1'b1;
            req          = reqTab[i];
            entry.testId = i;
            entry.due    = cycleCount + 1;
            entry.req    = reqTab[i];
            entry.exp    = expTab[i];
            pending.push_back(entry);
            for (int g = 0; g < gapTab[i]; g++)
            begin
                @(posedge clk);
                #1;
                reqValid = 1'b0;
                req      = ~reqTab[i];  // junk that must be ignored
            end
        end
        @(posedge clk);
        #1;
        reqValid = 1'b0;

        while (pending.size() != 0)
            @(posedge clk);
        repeat (4) @(posedge clk);  // watch for stray responses

        $display("summary: %0d of %0d tests done, %0d failed, %0d errors",
                 testsDone, numTests, testsFailed, errorCount);
        if (errorCount == 0 && testsDone == numTests)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== alu_props.sv ====
// property checker bound to the ALU result stage for strobe timing and flag consistency
`timescale 1ns/1ps

module aluProps
(
    input logic               clk,
    input logic               rstN,
    input logic               reqValid,
    input aluOpPkg::aluOpT    op,
    input logic               respValid,
    input aluResPkg::aluRespT resp
);
    import aluOpPkg::*;
    import aluResPkg::*;

    logic arithOp;  // add or sub

    assign arithOp = (op == opAdd) || (op == opSub);

    // each strobe is answered on the next cycle
    respAfterReq: assert property (@(posedge clk) disable iff (!rstN)
        reqValid |=> respValid)
        else $error("respValid missing one cycle after reqValid");

    noRespWhenIdle: assert property (@(posedge clk) disable iff (!rstN)
        !reqValid |=> !respValid)
        else $error("respValid raised without a request on the cycle before");

    zeroFlagMatches: assert property (@(posedge clk) disable iff (!rstN)
        respValid |-> (resp.flags.zero == (resp.result == '0)))
        else $error("zero flag disagrees with the result");

    // slt, logic and illegal codes never report carry or overflow
    arithFlagsOnlyForArith: assert property (@(posedge clk) disable iff (!rstN)
        (reqValid && !arithOp) |=> (!resp.flags.carry && !resp.flags.overflow))
        else $error("carry or overflow set for an opcode other than add or sub");

endmodule

bind resultSelect aluProps i_aluProps
(
    .clk       (clk),
    .rstN      (rstN),
    .reqValid  (reqValid),
    .op        (op),
    .respValid (respValid),
    .resp      (resp)
);

// ==== logicUnit.sv ====
// bitwise logic unit for AND, OR, XOR, NOR and NAND selected by opcode
`timescale 1ns/1ps

module logicUnit
(
    input  logic [aluOpPkg::dataWidth-1:0] a,
    input  logic [aluOpPkg::dataWidth-1:0] b,
    input  aluOpPkg::aluOpT                op,
    output logic [aluOpPkg::dataWidth-1:0] logicResult
);
    import aluOpPkg::*;

    logic [dataWidth-1:0] andWord;
    logic [dataWidth-1:0] orWord;
    logic [dataWidth-1:0] xorWord;

    assign andWord = a & b;
    assign orWord  = a | b;
    assign xorWord = a ^ b;

    // nor and nand reuse the or and and terms
    always_comb
    begin
        case (op)
            opAnd:   logicResult = andWord;
            opOr:    logicResult = orWord;
            opXor:   logicResult = xorWord;
            opNor:   logicResult = ~orWord;
            opNand:  logicResult = ~andWord;
            default: logicResult = '0;  // arithmetic and illegal codes
        endcase
    end

endmodule

// ==== resultSelect.sv ====
// result stage that merges both units, forms slt and the flags, and registers the response
`timescale 1ns/1ps

module resultSelect
(
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           reqValid,
    input  aluOpPkg::aluOpT                op,
    input  aluResPkg::addOutT              addOut,
    input  logic [aluOpPkg::dataWidth-1:0] logicResult,
    output logic                           respValid,
    output aluResPkg::aluRespT             resp
);
    import aluOpPkg::*;
    import aluResPkg::*;

    logic                 isArith;   // add or sub
    logic                 lessThan;
    logic [dataWidth-1:0] result;
    aluFlagsT             flags;
    aluRespT              nextResp;

    // signed compare from the subtractor sign corrected by overflow
    assign lessThan = addOut.sum[dataWidth-1] ^ addOut.overflow;

    always_comb
    begin
        isArith = 1'b0;
        case (op)
            opAdd,
            opSub:
            begin
                isArith = 1'b1;
                result  = addOut.sum;
            end
            opSlt:   result = {{(dataWidth-1){1'b0}}, lessThan};
            default: result = logicResult;  // already zero for illegal codes
        endcase
    end

    always_comb
    begin
        flags.zero     = (result == '0);
        flags.negative = result[dataWidth-1];
        flags.carry    = isArith & addOut.carry;
        flags.overflow = isArith & addOut.overflow;
    end

    assign nextResp.result = result;
    assign nextResp.flags  = flags;

    // resp holds between strobes
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            respValid <= 1'b0;
            resp      <= '0;
        end
        else
        begin
            respValid <= reqValid;
            if (reqValid)
                resp <= nextResp;
        end
    end

endmodule

// ==== verilog.f ====
aluOpPkg.sv
aluResPkg.sv
addSubUnit.sv
logicUnit.sv
resultSelect.sv
alu32.sv
alu_props.sv
aluTb.sv
